//--- source/llc_mem_pkg.sv
////////////////////
// llc memory types
////////////////////

`default_nettype none

package llc_mem_pkg;

    // organization, ways must stay even since two ways share one ram
    localparam int llc_ways = 4;
    localparam int llc_way_bits = 2;

    // set index and its split into bank select and bank address
    localparam int llc_set_bits = 8;
    localparam int llc_bank_bits = 1;
    localparam int llc_bank_addr_bits = llc_set_bits - llc_bank_bits;
    localparam int llc_banks = 2 ** llc_bank_bits;
    localparam int llc_bank_depth = 2 ** llc_bank_addr_bits;

    // entry field widths
    localparam int llc_tag_bits = 16;
    localparam int llc_line_bits = 128;
    localparam int llc_sharers_bits = 16;
    localparam int llc_state_bits = 3;

    // set index
    typedef logic [llc_set_bits-1:0] llc_set_t;

    // way index
    typedef logic [llc_way_bits-1:0] llc_way_t;

    // one bit per way
    typedef logic [llc_ways-1:0] llc_way_mask_t;

    // bank select taken from the set msbs
    typedef logic [llc_bank_bits-1:0] llc_bank_t;

    // address inside one bank
    typedef logic [llc_bank_addr_bits-1:0] llc_bank_addr_t;

    typedef logic [llc_tag_bits-1:0] llc_tag_t;

    typedef logic [llc_line_bits-1:0] llc_line_t;

    // one bit per private cache holding the line
    typedef logic [llc_sharers_bits-1:0] llc_sharers_t;

    // coherence state as stored, decoded by the controller
    typedef logic [llc_state_bits-1:0] llc_state_t;

    // one cache entry, 164 bits
    typedef struct packed {
        llc_tag_t     tag;
        llc_state_t   state;
        logic         dirty;
        llc_sharers_t sharers;
        llc_line_t    line;
    } llc_entry_t;

endpackage

`default_nettype wire

//--- source/llc_dp_ram.sv
////////////////////
// dual-port ram
////////////////////

`default_nettype none

module llc_dp_ram #(
    parameter int width = 8
) (
    input  logic                                   clk,
    input  logic [llc_mem_pkg::llc_bank_addr_bits:0] a_addr,
    input  logic [llc_mem_pkg::llc_bank_addr_bits:0] b_addr,
    input  logic [width-1:0]                       a_din,
    input  logic [width-1:0]                       b_din,
    input  logic                                   a_we,
    input  logic                                   b_we,
    input  logic                                   a_ce,
    input  logic                                   b_ce,
    output logic [width-1:0]                       a_dout,
    output logic [width-1:0]                       b_dout
);

    // two ways per ram, the address msb picks the way
    logic [width-1:0] mem [2*llc_mem_pkg::llc_bank_depth];

    // ports never collide since their address msbs differ
    always_ff @(posedge clk) begin
        if (a_we) begin
            mem[a_addr] <= a_din;
        end
        if (b_we) begin
            mem[b_addr] <= b_din;
        end
    end

    // read-first, output holds while ce is low
    always_ff @(posedge clk) begin
        if (a_ce) begin
            a_dout <= mem[a_addr];
        end
        if (b_ce) begin
            b_dout <= mem[b_addr];
        end
    end

endmodule

`default_nettype wire

//--- source/llc_write_decode.sv
////////////////////
// write decoder
////////////////////

`default_nettype none

module llc_write_decode (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wr_en,
    input  llc_mem_pkg::llc_way_t      way,
    input  llc_mem_pkg::llc_way_mask_t wr_rst_flush,
    input  llc_mem_pkg::llc_set_t      set_in,
    output llc_mem_pkg::llc_way_mask_t way_we,
    output llc_mem_pkg::llc_way_mask_t way_fe,
    output logic [llc_mem_pkg::llc_banks-1:0] bank_we
);

    llc_mem_pkg::llc_bank_t wr_bank;
    logic wr_any;

    assign wr_bank = set_in[llc_mem_pkg::llc_set_bits-1 -: llc_mem_pkg::llc_bank_bits];

    // any entry write, full or flush, opens the addressed bank
    assign wr_any = wr_en || (|wr_rst_flush);

    // per-way enables
    // a full write takes priority, so flush only marks ways not fully written
    always_comb begin
        for (int i = 0; i < llc_mem_pkg::llc_ways; i++) begin
            way_we[i] = wr_en && (way == llc_mem_pkg::llc_way_t'(i));
            way_fe[i] = wr_rst_flush[i] && !way_we[i];
        end
    end

    // only the bank named by the set msbs
    always_comb begin
        for (int b = 0; b < llc_mem_pkg::llc_banks; b++) begin
            bank_we[b] = wr_any && (wr_bank == llc_mem_pkg::llc_bank_t'(b));
        end
    end

    // at most one way takes a full entry per cycle
    way_we_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(way_we)
    ) else begin
        $error("way_we not one-hot: %b", way_we);
    end

    // the controller must present a clean way and set with every write
    wr_addr_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_any |-> !$isunknown({way, set_in})
    ) else begin
        $error("write with unknown way or set");
    end

endmodule

`default_nettype wire

//--- source/llc_way_pair.sv
////////////////////
// way pair storage
////////////////////

`default_nettype none

module llc_way_pair #(
    parameter int pair_index = 0
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       rd_en,
    input  llc_mem_pkg::llc_set_t      set_in,
    input  llc_mem_pkg::llc_entry_t    wr_entry,
    input  llc_mem_pkg::llc_way_mask_t way_we,
    input  llc_mem_pkg::llc_way_mask_t way_fe,
    input  logic [llc_mem_pkg::llc_banks-1:0] bank_we,
    output llc_mem_pkg::llc_entry_t    rd_lo,
    output llc_mem_pkg::llc_entry_t    rd_hi
);

    llc_mem_pkg::llc_bank_addr_t bank_addr;
    llc_mem_pkg::llc_bank_t      rd_bank_q;

    // full enables for tag and line, full-or-flush for the coherence fields
    logic lo_full;
    logic hi_full;
    logic lo_meta;
    logic hi_meta;

    // registered outputs of every bank, per way of the pair
    llc_mem_pkg::llc_entry_t lo_bank [llc_mem_pkg::llc_banks];
    llc_mem_pkg::llc_entry_t hi_bank [llc_mem_pkg::llc_banks];

    assign bank_addr = set_in[llc_mem_pkg::llc_bank_addr_bits-1:0];

    assign lo_full = way_we[2*pair_index];
    assign hi_full = way_we[2*pair_index+1];
    assign lo_meta = way_we[2*pair_index] | way_fe[2*pair_index];
    assign hi_meta = way_we[2*pair_index+1] | way_fe[2*pair_index+1];

    // port a holds the even way in the lower half, port b the odd way above
    for (genvar b = 0; b < llc_mem_pkg::llc_banks; b++) begin : g_bank
        llc_dp_ram #(.width(llc_mem_pkg::llc_tag_bits)) tag_ram (
            .clk    (clk),
            .a_addr ({1'b0, bank_addr}),
            .b_addr ({1'b1, bank_addr}),
            .a_din  (wr_entry.tag),
            .b_din  (wr_entry.tag),
            .a_we   (lo_full & bank_we[b]),
            .b_we   (hi_full & bank_we[b]),
            .a_ce   (rd_en),
            .b_ce   (rd_en),
            .a_dout (lo_bank[b].tag),
            .b_dout (hi_bank[b].tag)
        );

        llc_dp_ram #(.width(llc_mem_pkg::llc_state_bits)) state_ram (
            .clk    (clk),
            .a_addr ({1'b0, bank_addr}),
            .b_addr ({1'b1, bank_addr}),
            .a_din  (wr_entry.state),
            .b_din  (wr_entry.state),
            .a_we   (lo_meta & bank_we[b]),
            .b_we   (hi_meta & bank_we[b]),
            .a_ce   (rd_en),
            .b_ce   (rd_en),
            .a_dout (lo_bank[b].state),
            .b_dout (hi_bank[b].state)
        );

        llc_dp_ram #(.width(1)) dirty_ram (
            .clk    (clk),
            .a_addr ({1'b0, bank_addr}),
            .b_addr ({1'b1, bank_addr}),
            .a_din  (wr_entry.dirty),
            .b_din  (wr_entry.dirty),
            .a_we   (lo_meta & bank_we[b]),
            .b_we   (hi_meta & bank_we[b]),
            .a_ce   (rd_en),
            .b_ce   (rd_en),
            .a_dout (lo_bank[b].dirty),
            .b_dout (hi_bank[b].dirty)
        );

        llc_dp_ram #(.width(llc_mem_pkg::llc_sharers_bits)) sharers_ram (
            .clk    (clk),
            .a_addr ({1'b0, bank_addr}),
            .b_addr ({1'b1, bank_addr}),
            .a_din  (wr_entry.sharers),
            .b_din  (wr_entry.sharers),
            .a_we   (lo_meta & bank_we[b]),
            .b_we   (hi_meta & bank_we[b]),
            .a_ce   (rd_en),
            .b_ce   (rd_en),
            .a_dout (lo_bank[b].sharers),
            .b_dout (hi_bank[b].sharers)
        );

        llc_dp_ram #(.width(llc_mem_pkg::llc_line_bits)) line_ram (
            .clk    (clk),
            .a_addr ({1'b0, bank_addr}),
            .b_addr ({1'b1, bank_addr}),
            .a_din  (wr_entry.line),
            .b_din  (wr_entry.line),
            .a_we   (lo_full & bank_we[b]),
            .b_we   (hi_full & bank_we[b]),
            .a_ce   (rd_en),
            .b_ce   (rd_en),
            .a_dout (lo_bank[b].line),
            .b_dout (hi_bank[b].line)
        );
    end

    // bank select follows the read, not the live set index
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_bank_q <= set_in[llc_mem_pkg::llc_set_bits-1 -: llc_mem_pkg::llc_bank_bits];
        end
    end

    always_comb begin
        rd_lo = lo_bank[rd_bank_q];
        rd_hi = hi_bank[rd_bank_q];
    end

    rd_bank_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_en |=> !$isunknown(rd_bank_q)
    ) else begin
        $error("read bank select unknown after rd_en");
    end

endmodule

`default_nettype wire

//--- source/llc_evict_mem.sv
////////////////////
// eviction way store
////////////////////

`default_nettype none

module llc_evict_mem (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rd_en,
    input  llc_mem_pkg::llc_set_t set_in,
    input  logic                  wr_en_evict_way,
    input  llc_mem_pkg::llc_way_t wr_evict_way,
    output llc_mem_pkg::llc_way_t rd_evict_way
);

    llc_mem_pkg::llc_bank_t      bank;
    llc_mem_pkg::llc_bank_t      rd_bank_q;
    llc_mem_pkg::llc_bank_addr_t bank_addr;

    // registered read of every bank
    llc_mem_pkg::llc_way_t bank_dout [llc_mem_pkg::llc_banks];

    assign bank = set_in[llc_mem_pkg::llc_set_bits-1 -: llc_mem_pkg::llc_bank_bits];
    assign bank_addr = set_in[llc_mem_pkg::llc_bank_addr_bits-1:0];

    // one pointer per set, single port per bank
    for (genvar b = 0; b < llc_mem_pkg::llc_banks; b++) begin : g_bank
        llc_mem_pkg::llc_way_t mem [llc_mem_pkg::llc_bank_depth];

        always_ff @(posedge clk) begin
            if (wr_en_evict_way && (bank == llc_mem_pkg::llc_bank_t'(b))) begin
                mem[bank_addr] <= wr_evict_way;
            end
            // read-first on a same-edge write
            if (rd_en) begin
                bank_dout[b] <= mem[bank_addr];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_bank_q <= bank;
        end
    end

    assign rd_evict_way = bank_dout[rd_bank_q];

    // a pointer write to an unknown set would corrupt some bank silently
    evict_set_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en_evict_way |-> !$isunknown(set_in)
    ) else begin
        $error("evict way write with unknown set_in");
    end

endmodule

`default_nettype wire

//--- source/llc_localmem.sv
////////////////////
// llc local memory
////////////////////

`default_nettype none

module llc_localmem (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       rd_en,
    input  logic                       wr_en,
    input  logic                       wr_en_evict_way,
    input  llc_mem_pkg::llc_set_t      set_in,
    input  llc_mem_pkg::llc_way_t      way,
    input  llc_mem_pkg::llc_entry_t    wr_entry,
    input  llc_mem_pkg::llc_way_mask_t wr_rst_flush,
    input  llc_mem_pkg::llc_way_t      wr_evict_way,
    output llc_mem_pkg::llc_entry_t    rd_entry [llc_mem_pkg::llc_ways],
    output llc_mem_pkg::llc_way_t      rd_evict_way
);

    // full-entry and flush-only enables per way
    llc_mem_pkg::llc_way_mask_t way_we;
    llc_mem_pkg::llc_way_mask_t way_fe;

    // addressed bank, shared by every way
    logic [llc_mem_pkg::llc_banks-1:0] bank_we;

    llc_write_decode u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (wr_en),
        .way          (way),
        .wr_rst_flush (wr_rst_flush),
        .set_in       (set_in),
        .way_we       (way_we),
        .way_fe       (way_fe),
        .bank_we      (bank_we)
    );

    // two ways per pair, each pair reads its set in parallel with the others
    for (genvar p = 0; p < llc_mem_pkg::llc_ways / 2; p++) begin : g_pair
        llc_way_pair #(
            .pair_index (p)
        ) u_pair (
            .clk      (clk),
            .rst_n    (rst_n),
            .rd_en    (rd_en),
            .set_in   (set_in),
            .wr_entry (wr_entry),
            .way_we   (way_we),
            .way_fe   (way_fe),
            .bank_we  (bank_we),
            .rd_lo    (rd_entry[2*p]),
            .rd_hi    (rd_entry[2*p+1])
        );
    end

    // pointer store is written on its own strobe
    llc_evict_mem u_evict (
        .clk             (clk),
        .rst_n           (rst_n),
        .rd_en           (rd_en),
        .set_in          (set_in),
        .wr_en_evict_way (wr_en_evict_way),
        .wr_evict_way    (wr_evict_way),
        .rd_evict_way    (rd_evict_way)
    );

endmodule

`default_nettype wire

//--- verif/tb_llc_localmem.sv
////////////////////
// llc local memory testbench
////////////////////

`default_nettype none

module tb_llc_localmem;

    logic clk;
    logic rst_n;
    logic rd_en;
    logic wr_en;
    logic wr_en_evict_way;
    llc_mem_pkg::llc_set_t      set_in;
    llc_mem_pkg::llc_way_t      way;
    llc_mem_pkg::llc_entry_t    wr_entry;
    llc_mem_pkg::llc_way_mask_t wr_rst_flush;
    llc_mem_pkg::llc_way_t      wr_evict_way;
    llc_mem_pkg::llc_entry_t    rd_entry [llc_mem_pkg::llc_ways];
    llc_mem_pkg::llc_way_t      rd_evict_way;

    // reference model per way and set
    llc_mem_pkg::llc_entry_t model_entry [llc_mem_pkg::llc_ways][2**llc_mem_pkg::llc_set_bits];
    llc_mem_pkg::llc_way_t   model_evict [2**llc_mem_pkg::llc_set_bits];

    // model contents captured at the most recent read edge
    llc_mem_pkg::llc_entry_t exp_entry [llc_mem_pkg::llc_ways];
    llc_mem_pkg::llc_way_t   exp_evict;

    logic have_read;
    logic rd_q;
    int   reads_issued;
    int   reads_checked;

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    llc_localmem dut0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .rd_en           (rd_en),
        .wr_en           (wr_en),
        .wr_en_evict_way (wr_en_evict_way),
        .set_in          (set_in),
        .way             (way),
        .wr_entry        (wr_entry),
        .wr_rst_flush    (wr_rst_flush),
        .wr_evict_way    (wr_evict_way),
        .rd_entry        (rd_entry),
        .rd_evict_way    (rd_evict_way)
    );

    // a full write wins over a flush of the same way
    // reads capture the model before this edge's writes land
    always @(posedge clk) begin
        for (int w = 0; w < llc_mem_pkg::llc_ways; w++) begin
            if (wr_en && way == llc_mem_pkg::llc_way_t'(w)) begin
                model_entry[w][set_in] <= wr_entry;
            end else if (wr_rst_flush[w]) begin
                model_entry[w][set_in].state <= wr_entry.state;
                model_entry[w][set_in].dirty <= wr_entry.dirty;
                model_entry[w][set_in].sharers <= wr_entry.sharers;
            end
            if (rd_en) begin
                exp_entry[w] <= model_entry[w][set_in];
            end
        end
        if (wr_en_evict_way) begin
            model_evict[set_in] <= wr_evict_way;
        end
        if (rd_en) begin
            exp_evict <= model_evict[set_in];
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            have_read <= 1'b0;
            rd_q <= 1'b0;
        end else begin
            rd_q <= rd_en;
            if (rd_en) begin
                have_read <= 1'b1;
            end
        end
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string name,
                                   input logic [$bits(llc_mem_pkg::llc_entry_t)-1:0] expected,
                                   input logic [$bits(llc_mem_pkg::llc_entry_t)-1:0] actual);
        $display("Error at time %0t: %s expected %0h actual %0h", $time, name, expected, actual);
        abort_run();
    endtask

    // the cycle after a read, and every idle cycle after it, shows the captured entry
    for (genvar w = 0; w < llc_mem_pkg::llc_ways; w++) begin : g_check
        entry_match: assert property (
            @(posedge clk) disable iff (!rst_n)
            (rd_en || have_read) |=> rd_entry[w] === exp_entry[w]
        ) else begin
            report_mismatch($sformatf("rd_entry[%0d]", w),
                            $sampled(exp_entry[w]), $sampled(rd_entry[w]));
        end
    end

    // a read counts once its pointer comparison has passed
    evict_match: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rd_en || have_read) |=> rd_evict_way === exp_evict
    ) begin
        if ($sampled(rd_q)) begin
            reads_checked++;
        end
    end else begin
        report_mismatch("rd_evict_way", $sampled(exp_evict), $sampled(rd_evict_way));
    end

    function automatic llc_mem_pkg::llc_entry_t random_entry();
        llc_mem_pkg::llc_entry_t e;
        e.tag = llc_mem_pkg::llc_tag_t'($urandom);
        e.state = llc_mem_pkg::llc_state_t'($urandom);
        e.dirty = 1'($urandom);
        e.sharers = llc_mem_pkg::llc_sharers_t'($urandom);
        e.line = {$urandom, $urandom, $urandom, $urandom};
        return e;
    endfunction

    task automatic drive_cycle(input logic rd, input logic wr, input llc_mem_pkg::llc_way_t w,
                               input llc_mem_pkg::llc_entry_t e,
                               input llc_mem_pkg::llc_way_mask_t fl, input logic ev,
                               input llc_mem_pkg::llc_way_t ev_way,
                               input llc_mem_pkg::llc_set_t s);
        @(posedge clk);
        rd_en <= rd;
        wr_en <= wr;
        way <= w;
        wr_entry <= e;
        wr_rst_flush <= fl;
        wr_en_evict_way <= ev;
        wr_evict_way <= ev_way;
        set_in <= s;
        if (rd) begin
            reads_issued++;
        end
    endtask

    task automatic read_set(input llc_mem_pkg::llc_set_t s);
        drive_cycle(1'b1, 1'b0, '0, '0, '0, 1'b0, '0, s);
    endtask

    initial begin
        llc_mem_pkg::llc_set_t s;
        logic done;
        void'($urandom(32'h338d5fd2));
        rst_n = 1'b0;
        rd_en = 1'b0;
        wr_en = 1'b0;
        wr_en_evict_way = 1'b0;
        set_in = '0;
        way = '0;
        wr_entry = '0;
        wr_rst_flush = '0;
        wr_evict_way = '0;
        reads_issued = 0;
        reads_checked = 0;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
        end
        rst_n <= 1'b1;

        // fill every set of both banks and write each pointer with way 0
        for (int i = 0; i < 2 ** llc_mem_pkg::llc_set_bits; i++) begin
            for (int j = 0; j < llc_mem_pkg::llc_ways; j++) begin
                drive_cycle(1'b0, 1'b1, llc_mem_pkg::llc_way_t'(j), random_entry(), '0,
                            j == 0, llc_mem_pkg::llc_way_t'($urandom),
                            llc_mem_pkg::llc_set_t'(i));
            end
        end
        for (int i = 0; i < 2 ** llc_mem_pkg::llc_set_bits; i++) begin
            read_set(llc_mem_pkg::llc_set_t'(i));
        end

        // single-way writes must leave the other ways of the set alone
        for (int i = 0; i < 200; i++) begin
            s = llc_mem_pkg::llc_set_t'($urandom);
            drive_cycle(1'b0, 1'b1, llc_mem_pkg::llc_way_t'($urandom), random_entry(), '0,
                        1'b0, '0, s);
            read_set(s);
        end

        // flushes now and then together with a full write
        for (int i = 0; i < 60; i++) begin
            s = llc_mem_pkg::llc_set_t'($urandom);
            drive_cycle(1'b0, ($urandom % 4) == 0, llc_mem_pkg::llc_way_t'($urandom),
                        random_entry(), llc_mem_pkg::llc_way_mask_t'($urandom), 1'b0, '0, s);
            read_set(s);
        end

        // pointer write followed by an entry write on the same set
        for (int i = 0; i < 60; i++) begin
            s = llc_mem_pkg::llc_set_t'($urandom);
            drive_cycle(1'b0, 1'b0, '0, '0, '0, 1'b1, llc_mem_pkg::llc_way_t'($urandom), s);
            drive_cycle(1'b0, 1'b1, llc_mem_pkg::llc_way_t'($urandom), random_entry(), '0,
                        1'b0, '0, s);
            read_set(s);
        end

        // outputs hold while set_in wanders
        for (int i = 0; i < 20; i++) begin
            read_set(llc_mem_pkg::llc_set_t'($urandom));
            for (int j = 0; j < 6; j++) begin
                drive_cycle(1'b0, 1'b0, '0, '0, '0, 1'b0, '0, llc_mem_pkg::llc_set_t'($urandom));
            end
        end

        // read and write on the same edge before reading the new contents
        for (int i = 0; i < 40; i++) begin
            s = llc_mem_pkg::llc_set_t'($urandom);
            drive_cycle(1'b1, 1'b1, llc_mem_pkg::llc_way_t'($urandom), random_entry(), '0,
                        1'b1, llc_mem_pkg::llc_way_t'($urandom), s);
            read_set(s);
        end

        drive_cycle(1'b0, 1'b0, '0, '0, '0, 1'b0, '0, '0);
        done = 1'b0;
        for (int n = 0; n < 20 && !done; n++) begin
            @(posedge clk);
            done = (reads_checked == reads_issued);
        end
        if (!done) begin
            $display("timeout: %0d reads issued but only %0d checked", reads_issued,
                     reads_checked);
            abort_run();
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- list.f
source/llc_mem_pkg.sv
source/llc_dp_ram.sv
source/llc_write_decode.sv
source/llc_way_pair.sv
source/llc_evict_mem.sv
source/llc_localmem.sv
verif/tb_llc_localmem.sv
